// File: cache_bank.f
+incdir+logic
logic/cache_bank_pkg.sv
logic/bank_if.sv
logic/tag_store.sv
logic/data_store.sv
logic/miss_tracker.sv
logic/sync_fifo.sv
logic/bank_pipeline.sv
logic/cache_bank.sv
sim/mem_model.sv
sim/cache_bank_tb.sv

// File: Makefile
# Verilator build and run for the cache bank testbench

VERILATOR ?= verilator
TOP       ?= cache_bank_tb
FILELIST  ?= cache_bank.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal

SIM     = $(BUILD_DIR)/V$(TOP)
SOURCES = $(wildcard logic/*.sv logic/*.svh sim/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP) -f $(FILELIST)

# the simulator status is ignored, the log decides
run: $(SIM)
	-$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^STATUS: PASS$$" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: sim/cache_bank_tb.sv
//////////////////////////////
// cache bank testbench
// directed and random traffic
// against a byte shadow memory
//////////////////////////////
`timescale 1ns/1ps
`include "cache_bank_config.svh"

module cache_bank_tb;
    import cache_bank_pkg::*;

    localparam int     NUM_OPS    = 400;
    localparam int     LINE_BYTES = `CB_WORD_BYTES * `CB_WORDS_PER_LINE;
    localparam int     MEM_BYTES  = LINE_BYTES << `CB_LINE_ADDR_BITS;
    localparam int     NUM_TAGS   = 1 << `CB_REQ_TAG_BITS;
    localparam int     MAX_WRITES = NUM_OPS + 64;
    localparam longint TIMEOUT_NS = longint'(NUM_OPS) * 200 * 20;

    logic         clk = 1'b0;
    logic         reset;
    logic         core_req_valid;
    logic         core_req_ready;
    line_addr_t   core_req_addr;
    logic         core_req_rw;
    word_sel_t    core_req_wsel;
    word_byteen_t core_req_byteen;
    word_t        core_req_data;
    req_tag_t     core_req_tag;
    logic         core_rsp_valid;
    logic         core_rsp_ready;
    word_t        core_rsp_data;
    req_tag_t     core_rsp_tag;
    logic         mem_req_valid;
    logic         mem_req_ready;
    logic         mem_req_rw;
    line_addr_t   mem_req_addr;
    line_byteen_t mem_req_byteen;
    line_t        mem_req_data;
    logic         mem_rsp_valid;
    logic         mem_rsp_ready;
    line_t        mem_rsp_data;

    // shadow memory and bookkeeping
    logic [7:0]   shadow [MEM_BYTES];
    word_t        expected [NUM_TAGS];
    int           issued [NUM_TAGS];
    int           answered [NUM_TAGS];
    line_addr_t   wr_addr [MAX_WRITES];
    word_sel_t    wr_wsel [MAX_WRITES];
    word_byteen_t wr_be [MAX_WRITES];
    word_t        wr_data [MAX_WRITES];
    int           wr_issued;
    int           wr_seen;
    int           mem_reads;
    line_addr_t   last_read_addr;
    bit           backpressure;

    cache_bank dut (.*);
    mem_model  mem (.*);

    always #10 clk = ~clk;

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_error(input string what);
        stop_run($sformatf("Error at %0t ns: %s", $time, what));
    endtask

    task automatic report_mismatch(input string name, input logic [$bits(line_t)-1:0] got,
                                   input logic [$bits(line_t)-1:0] exp);
        stop_run($sformatf("Mismatch at %0t ns: %s is %0h, expected %0h", $time, name, got, exp));
    endtask

    // expected read data from the shadow bytes
    function automatic word_t ref_word(line_addr_t addr, word_sel_t wsel);
        word_t w;
        int    base;
        base = int'(addr) * LINE_BYTES + int'(wsel) * `CB_WORD_BYTES;
        for (int b = 0; b < `CB_WORD_BYTES; b++) begin
            w[b*8 +: 8] = shadow[base + b];
        end
        return w;
    endfunction

    function automatic line_byteen_t place_byteen(word_sel_t wsel, word_byteen_t be);
        line_byteen_t placed;
        placed = '0;
        placed[int'(wsel)*`CB_WORD_BYTES +: `CB_WORD_BYTES] = be;
        return placed;
    endfunction

    function automatic bit all_answered();
        for (int t = 0; t < NUM_TAGS; t++) begin
            if (issued[t] != answered[t]) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    // one core request, entered and left at 2 ns after an edge
    task automatic send(input logic rw, input line_addr_t addr, input word_sel_t wsel,
                        input word_byteen_t be, input word_t data);
        req_tag_t tag;
        int       base;
        tag = req_tag_t'($urandom);
        // a read needs a tag that is not in flight
        while (!rw && issued[tag] != answered[tag]) begin
            tag = tag + 1'b1;
            @(posedge clk);
            #2;
        end
        core_req_valid  = 1'b1;
        core_req_rw     = rw;
        core_req_addr   = addr;
        core_req_wsel   = wsel;
        core_req_byteen = be;
        core_req_data   = data;
        core_req_tag    = tag;
        do begin
            @(posedge clk);
        end while (!core_req_ready);
        if (rw) begin
            base = int'(addr) * LINE_BYTES + int'(wsel) * `CB_WORD_BYTES;
            for (int b = 0; b < `CB_WORD_BYTES; b++) begin
                if (be[b]) begin
                    shadow[base + b] = data[b*8 +: 8];
                end
            end
            wr_addr[wr_issued] = addr;
            wr_wsel[wr_issued] = wsel;
            wr_be[wr_issued]   = be;
            wr_data[wr_issued] = data;
            wr_issued++;
        end else begin
            expected[tag] = ref_word(addr, wsel);
            issued[tag]++;
        end
        #2;
        core_req_valid = 1'b0;
    endtask

    task automatic wait_idle();
        do begin
            @(posedge clk);
            #1;
        end while (!all_answered() || wr_seen != wr_issued);
        #1;
    endtask

    task automatic check_sweep();
        int low_cycles;
        low_cycles = 0;
        do begin
            @(posedge clk);
            assert (!mem_req_valid && !core_rsp_valid)
                else report_error("an output valid rose during the sweep");
            if (!core_req_ready) begin
                low_cycles++;
            end
        end while (!core_req_ready);
        assert (low_cycles >= `CB_LINES)
            else report_error($sformatf("core_req_ready rose after %0d cycles", low_cycles));
    endtask

    initial begin
        core_rsp_ready = 1'b0;
        forever begin
            @(posedge clk);
            if (backpressure) begin
                #2;
                core_rsp_ready = ($urandom_range(0, 2) != 0);
            end else begin
                #2;
                core_rsp_ready = 1'b1;
            end
        end
    end

    // every response against its tag
    always @(posedge clk) begin
        if (!reset && core_rsp_valid && core_rsp_ready) begin
            assert (issued[core_rsp_tag] != answered[core_rsp_tag])
                else report_error($sformatf("response for tag %0d not in flight", core_rsp_tag));
            assert (core_rsp_data == expected[core_rsp_tag])
                else report_mismatch("core_rsp_data", core_rsp_data, expected[core_rsp_tag]);
            answered[core_rsp_tag]++;
        end
    end

    // memory writes come out in the order the core sent them
    always @(posedge clk) begin
        if (!reset && mem_req_valid && mem_req_ready) begin
            if (!mem_req_rw) begin
                mem_reads++;
                last_read_addr = mem_req_addr;
            end else begin
                assert (wr_seen < wr_issued)
                    else report_error("memory write with no core write behind it");
                assert (mem_req_addr == wr_addr[wr_seen])
                    else report_mismatch("mem_req_addr", mem_req_addr, wr_addr[wr_seen]);
                assert (mem_req_byteen == place_byteen(wr_wsel[wr_seen], wr_be[wr_seen]))
                    else report_mismatch("mem_req_byteen", mem_req_byteen,
                                         place_byteen(wr_wsel[wr_seen], wr_be[wr_seen]));
                assert (mem_req_data == {`CB_WORDS_PER_LINE{wr_data[wr_seen]}})
                    else report_mismatch("mem_req_data", mem_req_data,
                                         {`CB_WORDS_PER_LINE{wr_data[wr_seen]}});
                wr_seen++;
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        report_error("watchdog timeout, the bank stopped answering");
    end

    initial begin
        int         reads_before;
        line_addr_t addr;
        void'($urandom(40));
        for (int i = 0; i < MEM_BYTES; i++) begin
            shadow[i] = 8'(i * 7 + 3) ^ 8'(i >> 8);
        end
        reset           = 1'b1;
        core_req_valid  = 1'b0;
        core_req_rw     = 1'b0;
        core_req_addr   = '0;
        core_req_wsel   = '0;
        core_req_byteen = '0;
        core_req_data   = '0;
        core_req_tag    = '0;
        repeat (3) @(posedge clk);
        #2;
        reset = 1'b0;
        check_sweep();
        #2;

        // first read misses and the second one hits
        reads_before = mem_reads;
        send(1'b0, 12'h0a5, 2'd2, 4'h0, 32'h0);
        wait_idle();
        assert (mem_reads == reads_before + 1)
            else report_error("read miss did not make exactly one memory read");
        assert (last_read_addr == 12'h0a5)
            else report_mismatch("mem_req_addr", last_read_addr, 12'h0a5);
        send(1'b0, 12'h0a5, 2'd3, 4'h0, 32'h0);
        wait_idle();
        assert (mem_reads == reads_before + 1)
            else report_error("read hit went out to memory");

        // byte writes to a cached and an uncached line
        send(1'b1, 12'h0a5, 2'd2, 4'b0101, 32'hdead_beef);
        send(1'b1, 12'h3c7, 2'd0, 4'b1110, 32'h1234_5678);
        send(1'b0, 12'h0a5, 2'd2, 4'h0, 32'h0);
        send(1'b0, 12'h3c7, 2'd0, 4'h0, 32'h0);
        wait_idle();

        // two tags in turn on the same index
        for (int i = 0; i < 12; i++) begin
            addr = {line_tag_t'(1 + i % 2), line_sel_t'(6)};
            send(i % 3 == 2, addr, word_sel_t'(i), 4'hf, word_t'($urandom));
        end
        wait_idle();

        // random mix under back-pressure
        backpressure = 1'b1;
        for (int i = 0; i < NUM_OPS; i++) begin
            addr = {line_tag_t'($urandom_range(0, 2)), line_sel_t'($urandom_range(0, 7))};
            send(1'($urandom_range(0, 1)), addr, word_sel_t'($urandom),
                 word_byteen_t'($urandom), word_t'($urandom));
            if ($urandom_range(0, 3) == 0) begin
                @(posedge clk);
                #2;
            end
        end
        wait_idle();

        // both queues drain once every request is done
        if (!core_rsp_valid && !mem_req_valid) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            report_error("items left in a queue after every request was done");
        end
    end

endmodule

// File: sim/mem_model.sv
//////////////////////////////
// memory model
// line memory with random latency
// and random request ready
//////////////////////////////
`timescale 1ns/1ps
`include "cache_bank_config.svh"

module mem_model (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         mem_req_valid,
    output logic                         mem_req_ready,
    input  logic                         mem_req_rw,
    input  cache_bank_pkg::line_addr_t   mem_req_addr,
    input  cache_bank_pkg::line_byteen_t mem_req_byteen,
    input  cache_bank_pkg::line_t        mem_req_data,
    output logic                         mem_rsp_valid,
    input  logic                         mem_rsp_ready,
    output cache_bank_pkg::line_t        mem_rsp_data
);
    import cache_bank_pkg::*;

    localparam int LINE_BYTES = `CB_WORD_BYTES * `CB_WORDS_PER_LINE;
    localparam int MEM_BYTES  = LINE_BYTES << `CB_LINE_ADDR_BITS;

    logic [7:0] bytes [MEM_BYTES];
    line_t      read_line;
    logic       read_waiting;
    logic       rsp_done;
    int         delay;
    int         base;

    initial begin
        // same start pattern as the testbench shadow
        for (int i = 0; i < MEM_BYTES; i++) begin
            bytes[i] = 8'(i * 7 + 3) ^ 8'(i >> 8);
        end
        mem_req_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp_data  = '0;
        read_waiting  = 1'b0;
        delay         = 0;
        forever begin
            @(posedge clk);
            rsp_done = mem_rsp_valid && mem_rsp_ready;
            if (!reset && mem_req_valid && mem_req_ready) begin
                base = int'(mem_req_addr) * LINE_BYTES;
                if (mem_req_rw) begin
                    for (int b = 0; b < LINE_BYTES; b++) begin
                        if (mem_req_byteen[b]) begin
                            bytes[base + b] = mem_req_data[b*8 +: 8];
                        end
                    end
                end else begin
                    // the line is read now and answered later
                    for (int b = 0; b < LINE_BYTES; b++) begin
                        read_line[b*8 +: 8] = bytes[base + b];
                    end
                    read_waiting = 1'b1;
                    delay        = $urandom_range(1, 8);
                end
            end
            #2;
            mem_req_ready = ($urandom_range(0, 3) != 0);
            if (rsp_done) begin
                mem_rsp_valid = 1'b0;
            end else if (read_waiting && !mem_rsp_valid) begin
                if (delay == 0) begin
                    mem_rsp_valid = 1'b1;
                    mem_rsp_data  = read_line;
                    read_waiting  = 1'b0;
                end else begin
                    delay--;
                end
            end
        end
    end

endmodule

// File: logic/cache_bank.sv
//////////////////////////////
// cache bank
// direct-mapped write-through bank
//////////////////////////////
`timescale 1ns/1ps
`include "cache_bank_config.svh"

module cache_bank (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         core_req_valid,
    output logic                         core_req_ready,
    input  cache_bank_pkg::line_addr_t   core_req_addr,
    input  logic                         core_req_rw,
    input  cache_bank_pkg::word_sel_t    core_req_wsel,
    input  cache_bank_pkg::word_byteen_t core_req_byteen,
    input  cache_bank_pkg::word_t        core_req_data,
    input  cache_bank_pkg::req_tag_t     core_req_tag,
    output logic                         core_rsp_valid,
    input  logic                         core_rsp_ready,
    output cache_bank_pkg::word_t        core_rsp_data,
    output cache_bank_pkg::req_tag_t     core_rsp_tag,
    output logic                         mem_req_valid,
    input  logic                         mem_req_ready,
    output logic                         mem_req_rw,
    output cache_bank_pkg::line_addr_t   mem_req_addr,
    output cache_bank_pkg::line_byteen_t mem_req_byteen,
    output cache_bank_pkg::line_t        mem_req_data,
    input  logic                         mem_rsp_valid,
    output logic                         mem_rsp_ready,
    input  cache_bank_pkg::line_t        mem_rsp_data
);
    import cache_bank_pkg::*;

    localparam int RSP_W  = $bits(req_tag_t) + $bits(word_t);
    localparam int MREQ_W = 1 + $bits(line_addr_t) + $bits(line_byteen_t) + $bits(line_t);

    logic              rsp_push;
    logic [RSP_W-1:0]  rsp_entry;
    logic              rsp_full;
    logic [RSP_W-1:0]  rsp_out;
    logic              mreq_push;
    logic [MREQ_W-1:0] mreq_entry;
    logic              mreq_full;
    logic [MREQ_W-1:0] mreq_out;

    miss_if  miss_bus ();
    array_if arr_bus ();

    bank_pipeline pipeline (
        .clk             (clk),
        .reset           (reset),
        .core_req_valid  (core_req_valid),
        .core_req_ready  (core_req_ready),
        .core_req_addr   (core_req_addr),
        .core_req_rw     (core_req_rw),
        .core_req_wsel   (core_req_wsel),
        .core_req_byteen (core_req_byteen),
        .core_req_data   (core_req_data),
        .core_req_tag    (core_req_tag),
        .rsp_push        (rsp_push),
        .rsp_entry       (rsp_entry),
        .rsp_full        (rsp_full),
        .mreq_push       (mreq_push),
        .mreq_entry      (mreq_entry),
        .mreq_full       (mreq_full),
        .miss            (miss_bus.pipeline),
        .arr             (arr_bus.ctrl)
    );

    tag_store tags (
        .clk   (clk),
        .reset (reset),
        .arr   (arr_bus.tags)
    );

    data_store data (
        .clk (clk),
        .arr (arr_bus.data)
    );

    miss_tracker tracker (
        .clk           (clk),
        .reset         (reset),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_ready (mem_rsp_ready),
        .mem_rsp_data  (mem_rsp_data),
        .miss          (miss_bus.tracker)
    );

    sync_fifo #(.WIDTH(RSP_W), .DEPTH(`CB_RSP_DEPTH)) rsp_queue (
        .clk      (clk),
        .reset    (reset),
        .push     (rsp_push),
        .data_in  (rsp_entry),
        .full     (rsp_full),
        .pop      (core_rsp_valid && core_rsp_ready),
        .data_out (rsp_out),
        .valid    (core_rsp_valid)
    );

    sync_fifo #(.WIDTH(MREQ_W), .DEPTH(`CB_MREQ_DEPTH)) mreq_queue (
        .clk      (clk),
        .reset    (reset),
        .push     (mreq_push),
        .data_in  (mreq_entry),
        .full     (mreq_full),
        .pop      (mem_req_valid && mem_req_ready),
        .data_out (mreq_out),
        .valid    (mem_req_valid)
    );

    assign {core_rsp_tag, core_rsp_data} = rsp_out;
    assign {mem_req_rw, mem_req_addr, mem_req_byteen, mem_req_data} = mreq_out;

endmodule

// File: logic/bank_pipeline.sv
//////////////////////////////
// bank pipeline
// init sweep, two request stages,
// stall control and array arbitration
//////////////////////////////
`timescale 1ns/1ps
`include "cache_bank_config.svh"

module bank_pipeline (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         core_req_valid,
    output logic                         core_req_ready,
    input  cache_bank_pkg::line_addr_t   core_req_addr,
    input  logic                         core_req_rw,
    input  cache_bank_pkg::word_sel_t    core_req_wsel,
    input  cache_bank_pkg::word_byteen_t core_req_byteen,
    input  cache_bank_pkg::word_t        core_req_data,
    input  cache_bank_pkg::req_tag_t     core_req_tag,
    output logic                         rsp_push,
    output logic [`CB_REQ_TAG_BITS+8*`CB_WORD_BYTES-1:0] rsp_entry,
    input  logic                         rsp_full,
    output logic                         mreq_push,
    // rw, addr, line byte enables, line data
    output logic [`CB_LINE_ADDR_BITS+9*`CB_WORD_BYTES*`CB_WORDS_PER_LINE:0] mreq_entry,
    input  logic                         mreq_full,
    miss_if.pipeline                     miss,
    array_if.ctrl                        arr
);
    import cache_bank_pkg::*;

    localparam int WORD_BITS = $bits(word_t);

    sweep_state_t state;
    line_sel_t    sweep_sel;

    logic         s0_valid;
    line_addr_t   s0_addr;
    logic         s0_rw;
    word_sel_t    s0_wsel;
    word_byteen_t s0_byteen;
    word_t        s0_data;
    req_tag_t     s0_tag;

    logic         s1_valid;
    line_addr_t   s1_addr;
    logic         s1_rw;
    word_sel_t    s1_wsel;
    word_byteen_t s1_byteen;
    word_t        s1_data;
    req_tag_t     s1_tag;

    logic         fill_xfer;
    logic         s1_rd_hit;
    logic         s1_rd_miss;
    logic         s1_wr;
    logic         s1_wr_conflict;
    logic         stall;
    word_t        rd_word;
    line_byteen_t mreq_byteen;

    // invalidate one line per cycle after reset
    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= SWEEP;
            sweep_sel <= '0;
        end else if (state == SWEEP) begin
            sweep_sel <= sweep_sel + 1'b1;
            if (sweep_sel == line_sel_t'(`CB_LINES - 1)) begin
                state <= RUN;
            end
        end
    end

    assign fill_xfer       = miss.fill_valid && miss.fill_ready;
    assign miss.fill_ready = !rsp_full;

    assign s1_rd_hit      = s1_valid && !s1_rw && arr.hit;
    assign s1_rd_miss     = s1_valid && !s1_rw && !arr.hit;
    assign s1_wr          = s1_valid && s1_rw;
    assign s1_wr_conflict = miss.busy && (s1_addr == miss.pending_addr);

    // a fill owns the response push and the array port in its cycle
    assign stall = (s1_rd_hit && (rsp_full || fill_xfer))
                || (s1_rd_miss && (miss.busy || mreq_full))
                || (s1_wr && (mreq_full || fill_xfer || s1_wr_conflict));

    assign core_req_ready = (state == RUN) && !stall;

    always_ff @(posedge clk) begin
        if (reset) begin
            s0_valid <= 1'b0;
            s1_valid <= 1'b0;
        end else if (!stall) begin
            s0_valid <= core_req_valid && core_req_ready;
            s1_valid <= s0_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            s0_addr   <= core_req_addr;
            s0_rw     <= core_req_rw;
            s0_wsel   <= core_req_wsel;
            s0_byteen <= core_req_byteen;
            s0_data   <= core_req_data;
            s0_tag    <= core_req_tag;
            s1_addr   <= s0_addr;
            s1_rw     <= s0_rw;
            s1_wsel   <= s0_wsel;
            s1_byteen <= s0_byteen;
            s1_data   <= s0_data;
            s1_tag    <= s0_tag;
        end
    end

    // core responses, fill word first
    assign rd_word   = arr.rd_line[s1_wsel*WORD_BITS +: WORD_BITS];
    assign rsp_push  = fill_xfer || (s1_rd_hit && !stall);
    assign rsp_entry = fill_xfer ? {miss.fill_tag, miss.fill_word} : {s1_tag, rd_word};

    // line read on a miss, write-through on every write
    assign mreq_byteen = s1_rw ? (line_byteen_t'(s1_byteen) << (s1_wsel * `CB_WORD_BYTES)) : '0;
    assign mreq_push   = (s1_rd_miss || s1_wr) && !stall;
    assign mreq_entry  = {s1_rw, s1_addr, mreq_byteen, {`CB_WORDS_PER_LINE{s1_data}}};

    assign miss.alloc      = s1_rd_miss && !stall;
    assign miss.alloc_addr = s1_addr;
    assign miss.alloc_wsel = s1_wsel;
    assign miss.alloc_tag  = s1_tag;

    // the lookup tag rides on wr_tag, a fill stalls stage 1 anyway
    assign arr.rd_sel    = line_sel_t'(s1_addr);
    assign arr.wr_tag    = fill_xfer ? line_tag_t'(miss.fill_addr >> $bits(line_sel_t))
                                     : line_tag_t'(s1_addr >> $bits(line_sel_t));
    assign arr.wr_line   = miss.fill_line;
    assign arr.word_we   = s1_wr && arr.hit && !stall;
    assign arr.wr_word   = s1_data;
    assign arr.wr_wsel   = s1_wsel;
    assign arr.wr_byteen = s1_byteen;

    always_comb begin
        arr.wr_sel   = line_sel_t'(s1_addr);
        arr.tag_we   = 1'b0;
        arr.wr_valid = 1'b0;
        arr.line_we  = 1'b0;
        if (state == SWEEP) begin
            arr.wr_sel = sweep_sel;
            arr.tag_we = 1'b1;
        end else if (fill_xfer) begin
            arr.wr_sel   = line_sel_t'(miss.fill_addr);
            arr.tag_we   = 1'b1;
            arr.wr_valid = 1'b1;
            arr.line_we  = 1'b1;
        end
    end

endmodule

// File: logic/sync_fifo.sv
//////////////////////////////
// synchronous FIFO
// circular buffer with a count
//////////////////////////////
`timescale 1ns/1ps

module sync_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 4
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             push,
    input  logic [WIDTH-1:0] data_in,
    output logic             full,
    input  logic             pop,
    output logic [WIDTH-1:0] data_out,
    output logic             valid
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [WIDTH-1:0]         mem [DEPTH];
    logic [PTR_W-1:0]         wr_ptr;
    logic [PTR_W-1:0]         rd_ptr;
    logic [$clog2(DEPTH+1)-1:0] count;
    logic                     do_push;
    logic                     do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + do_push - do_pop;
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= data_in;
        end
    end

    assign full     = (count == DEPTH);
    assign valid    = (count != 0);
    assign data_out = mem[rd_ptr];

endmodule

// File: logic/miss_tracker.sv
//////////////////////////////
// miss tracker
// one outstanding line read,
// hands the fill and missed word back
//////////////////////////////
`timescale 1ns/1ps

module miss_tracker (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  mem_rsp_valid,
    output logic                  mem_rsp_ready,
    input  cache_bank_pkg::line_t mem_rsp_data,
    miss_if.tracker               miss
);
    import cache_bank_pkg::*;

    localparam int WORD_BITS = $bits(word_t);

    logic       busy_q;
    line_addr_t addr_q;
    word_sel_t  wsel_q;
    req_tag_t   tag_q;
    logic       fill_xfer;

    assign fill_xfer = miss.fill_valid && miss.fill_ready;

    // busy from alloc until the fill is taken
    always_ff @(posedge clk) begin
        if (reset) begin
            busy_q <= 1'b0;
        end else if (miss.alloc) begin
            busy_q <= 1'b1;
        end else if (fill_xfer) begin
            busy_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (miss.alloc) begin
            addr_q <= miss.alloc_addr;
            wsel_q <= miss.alloc_wsel;
            tag_q  <= miss.alloc_tag;
        end
    end

    assign miss.busy         = busy_q;
    assign miss.pending_addr = addr_q;

    // memory answer goes straight through as the fill
    assign miss.fill_valid = busy_q && mem_rsp_valid;
    assign miss.fill_addr  = addr_q;
    assign miss.fill_line  = mem_rsp_data;
    assign miss.fill_word  = mem_rsp_data[wsel_q*WORD_BITS +: WORD_BITS];
    assign miss.fill_tag   = tag_q;

    assign mem_rsp_ready = busy_q && miss.fill_ready;

endmodule

// File: logic/data_store.sv
//////////////////////////////
// data store
// line array with fills and byte writes
//////////////////////////////
`timescale 1ns/1ps
`include "cache_bank_config.svh"

module data_store (
    input  logic  clk,
    array_if.data arr
);
    import cache_bank_pkg::*;

    line_t lines [`CB_LINES];

    // whole line on a fill, else merge bytes of one word
    always_ff @(posedge clk) begin
        if (arr.line_we) begin
            lines[arr.wr_sel] <= arr.wr_line;
        end else if (arr.word_we) begin
            for (int b = 0; b < `CB_WORD_BYTES; b++) begin
                if (arr.wr_byteen[b]) begin
                    lines[arr.wr_sel][(arr.wr_wsel*`CB_WORD_BYTES + b)*8 +: 8] <=
                        arr.wr_word[b*8 +: 8];
                end
            end
        end
    end

    // asynchronous read
    assign arr.rd_line = lines[arr.rd_sel];

endmodule

// File: logic/tag_store.sv
//////////////////////////////
// tag store
// tag and valid per line, hit compare
//////////////////////////////
`timescale 1ns/1ps
`include "cache_bank_config.svh"

module tag_store (
    input  logic  clk,
    input  logic  reset,
    array_if.tags arr
);
    import cache_bank_pkg::*;

    line_tag_t          tags [`CB_LINES];
    logic [`CB_LINES-1:0] valid;

    // valid bits, cleared by the sweep and set by fills
    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= '0;
        end else if (arr.tag_we) begin
            valid[arr.wr_sel] <= arr.wr_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (arr.tag_we) begin
            tags[arr.wr_sel] <= arr.wr_tag;
        end
    end

    // compare against the stage 1 tag on wr_tag
    assign arr.hit = valid[arr.rd_sel] && (tags[arr.rd_sel] == arr.wr_tag);

endmodule

// File: logic/bank_if.sv
//////////////////////////////
// bank interfaces
// miss tracker link and array port
//////////////////////////////
`timescale 1ns/1ps

interface miss_if;
    import cache_bank_pkg::*;

    logic       alloc;
    line_addr_t alloc_addr;
    word_sel_t  alloc_wsel;
    req_tag_t   alloc_tag;
    logic       fill_ready;
    logic       busy;
    line_addr_t pending_addr;
    logic       fill_valid;
    line_addr_t fill_addr;
    line_t      fill_line;
    word_t      fill_word;
    req_tag_t   fill_tag;

    modport pipeline (
        output alloc, alloc_addr, alloc_wsel, alloc_tag, fill_ready,
        input  busy, pending_addr, fill_valid, fill_addr, fill_line, fill_word, fill_tag
    );

    modport tracker (
        input  alloc, alloc_addr, alloc_wsel, alloc_tag, fill_ready,
        output busy, pending_addr, fill_valid, fill_addr, fill_line, fill_word, fill_tag
    );
endinterface

interface array_if;
    import cache_bank_pkg::*;

    line_sel_t    rd_sel;
    line_sel_t    wr_sel;
    logic         tag_we;
    line_tag_t    wr_tag;
    logic         wr_valid;
    logic         line_we;
    line_t        wr_line;
    logic         word_we;
    word_t        wr_word;
    word_sel_t    wr_wsel;
    word_byteen_t wr_byteen;
    logic         hit;
    line_t        rd_line;

    modport ctrl (
        output rd_sel, wr_sel, tag_we, wr_tag, wr_valid, line_we, wr_line,
        output word_we, wr_word, wr_wsel, wr_byteen,
        input  hit, rd_line
    );

    modport tags (
        input  rd_sel, wr_sel, tag_we, wr_tag, wr_valid,
        output hit
    );

    modport data (
        input  rd_sel, wr_sel, line_we, wr_line, word_we, wr_word, wr_wsel, wr_byteen,
        output rd_line
    );
endinterface

// File: logic/cache_bank_pkg.sv
//////////////////////////////
// cache bank types
// vector types and sweep FSM states
//////////////////////////////
`include "cache_bank_config.svh"

package cache_bank_pkg;

    // data path
    typedef logic [8*`CB_WORD_BYTES-1:0] word_t;
    typedef logic [`CB_WORD_BYTES-1:0] word_byteen_t;
    typedef logic [$clog2(`CB_WORDS_PER_LINE)-1:0] word_sel_t;
    typedef logic [8*`CB_WORD_BYTES*`CB_WORDS_PER_LINE-1:0] line_t;
    typedef logic [`CB_WORD_BYTES*`CB_WORDS_PER_LINE-1:0] line_byteen_t;

    // addressing, index in the low bits and tag above it
    typedef logic [`CB_LINE_ADDR_BITS-1:0] line_addr_t;
    typedef logic [$clog2(`CB_LINES)-1:0] line_sel_t;
    typedef logic [`CB_LINE_ADDR_BITS-$clog2(`CB_LINES)-1:0] line_tag_t;

    typedef logic [`CB_REQ_TAG_BITS-1:0] req_tag_t;

    // invalidation sweep after reset, then normal operation
    typedef enum logic {
        SWEEP,
        RUN
    } sweep_state_t;

endpackage

// File: logic/cache_bank_config.svh
//////////////////////////////
// cache bank sizes
// word, line and queue dimensions
//////////////////////////////
`ifndef CACHE_BANK_CONFIG_SVH
`define CACHE_BANK_CONFIG_SVH

// word and line geometry
`define CB_WORD_BYTES      4
`define CB_WORDS_PER_LINE  4
`define CB_LINES           16
`define CB_LINE_ADDR_BITS  12

// core side
`define CB_REQ_TAG_BITS    4
`define CB_RSP_DEPTH       4
`define CB_MREQ_DEPTH      4

`endif
